// ==== sifhTop.f ====
sifhPkg.sv
acqSequencer.sv
coarseHistogram.sv
fineHistogram.sv
peakCombiner.sv
sifhTop.sv
sifhChecker.sv
tb_sifhTop.sv

// ==== sifhVectors.txt ====
# S <ts hex>: one sample, order acq, pixel, sample (p0 p0 p1 p1 per acquisition)
# E <name> <r0 hex> <r1 hex>: expected pixel results after the frame above
# frame 1, coarse peaks bin 5 (tie with bin 3) and bin A
S 52
S 31
S A3
S A7
S 57
S 3A
S A5
S 20
S 90
S 11
S C1
S A0
# frame 2, windows 48 and 98, coarse peaks bin 0 and bin F
S 05
S 5C
S A2
S F1
S 07
S 5C
S B0
S F3
S 02
S F0
S A2
S B0
E tieAndWindow 5C A2
# frame 3, clamped windows 00 and E0
S 14
S 03
S EA
S F5
S 03
S 40
S F5
S FF
S 1F
S 80
S 10
S F5
E clampWindows 03 F5

// ==== run.sh ====
#!/bin/sh
# compile and run the sifh testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 -Wno-fatal --top-module tb_sifhTop -f sifhTop.f -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
exit 0

// ==== tb_sifhTop.sv ====
//**************************************
// sifh testbench
// clock, reset, vector reader and sample driver
//**************************************
`timescale 1ns/1ps

module tb_sifhTop;
    import sifhPkg::*;

    localparam int FRAME_LEN = PIXELS * SAMPLES_PER_PIXEL * ACQS_PER_FRAME;
    localparam int RES_BITS  = PIXELS * TS_BITS;
    localparam int NAME_BITS = 128;

    logic                 clk;
    logic                 combin_res;
    logic                 wrEn;
    timestampT            data;
    logic [RES_BITS-1:0]  result;
    logic                 resultValid;
    logic                 windowValid;

    // expectation sideband for the checker
    logic                 frameMark;
    logic                 expHasResult;
    logic [RES_BITS-1:0]  expResult;
    logic [NAME_BITS-1:0] expName;
    logic                 reportReq;
    int                   errorCount;
    int                   testCount;
    int                   checksDone;

    // vector file contents
    timestampT            samples[$];
    logic [RES_BITS-1:0]  expects[$];
    logic [NAME_BITS-1:0] names[$];

    sifhTop #(
        .PIXELS            (PIXELS),
        .SAMPLES_PER_PIXEL (SAMPLES_PER_PIXEL),
        .ACQS_PER_FRAME    (ACQS_PER_FRAME)
    ) DUT (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .result      (result),
        .resultValid (resultValid),
        .windowValid (windowValid)
    );

    sifhChecker #(
        .RES_BITS  (RES_BITS),
        .NAME_BITS (NAME_BITS)
    ) uChecker (
        .clk          (clk),
        .combin_res   (combin_res),
        .wrEn         (wrEn),
        .frameMark    (frameMark),
        .expHasResult (expHasResult),
        .expResult    (expResult),
        .expName      (expName),
        .result       (result),
        .resultValid  (resultValid),
        .windowValid  (windowValid),
        .reportReq    (reportReq),
        .errorCount   (errorCount),
        .testCount    (testCount),
        .checksDone   (checksDone)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //**************************************
    // vector file
    //**************************************
    // S lines are samples, E lines the results after a frame
    task automatic readVectors(output logic ok);
        int                   fd;
        string                line;
        timestampT            value;
        timestampT            r0;
        timestampT            r1;
        logic [NAME_BITS-1:0] name;
        fd = $fopen("sifhVectors.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            line = "";
            name = '0;
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) == "S") begin
                void'($sscanf(line, "S %h", value));
                samples.push_back(value);
            end else if (line.len() > 0 && line.getc(0) == "E") begin
                void'($sscanf(line, "E %s %h %h", name, r0, r1));
                names.push_back(name);
                // pixel 0 sits in the low byte
                expects.push_back({r1, r0});
            end
        end
        if (ok) begin
            $fclose(fd);
        end
        // one frame more than result lines
        ok = ok && (samples.size() == FRAME_LEN * (expects.size() + 1));
    endtask

    //**************************************
    // stimulus
    //**************************************
    // random idle gap of 0 to 3 cycles, then one strobe
    task automatic sendSample(input timestampT value, input logic last, input logic hasRes,
                              input logic [RES_BITS-1:0] expRes,
                              input logic [NAME_BITS-1:0] name);
        int gap;
        gap = $urandom % 4;
        repeat (gap) begin
            @(posedge clk);
            wrEn      <= 1'b0;
            frameMark <= 1'b0;
        end
        @(posedge clk);
        wrEn         <= 1'b1;
        data         <= value;
        frameMark    <= last;
        expHasResult <= hasRes;
        expResult    <= expRes;
        expName      <= name;
    endtask

    task automatic sendFrame(input int first, input logic hasRes,
                             input logic [RES_BITS-1:0] expRes,
                             input logic [NAME_BITS-1:0] name);
        for (int i = 0; i < FRAME_LEN; i++) begin
            sendSample(samples[first + i], i == FRAME_LEN - 1, hasRes, expRes, name);
        end
    endtask

    // reset in the middle of a frame
    task automatic pulseReset();
        @(posedge clk);
        wrEn       <= 1'b0;
        frameMark  <= 1'b0;
        combin_res <= 1'b0;
        repeat (2) @(posedge clk);
        combin_res <= 1'b1;
    endtask

    initial begin
        logic ok;
        int   cycles;
        combin_res   = 1'b0;
        wrEn         = 1'b0;
        data         = '0;
        frameMark    = 1'b0;
        expHasResult = 1'b0;
        expResult    = '0;
        expName      = '0;
        reportReq    = 1'b0;
        void'($urandom(32'h2faa9a4d));
        readVectors(ok);
        repeat (4) @(posedge clk);
        combin_res <= 1'b1;
        if (!ok) begin
            $display("vector file missing or not a whole number of frames");
        end else begin
            // first frame only opens the windows
            for (int f = 0; f <= expects.size(); f++) begin
                if (f == 0) begin
                    sendFrame(0, 1'b0, '0, "firstFrame");
                end else begin
                    sendFrame(f * FRAME_LEN, 1'b1, expects[f-1], names[f-1]);
                end
            end
            // half a frame, then restart from reset
            for (int i = 0; i < FRAME_LEN / 2; i++) begin
                sendSample(samples[i], 1'b0, 1'b0, '0, '0);
            end
            pulseReset();
            sendFrame(0, 1'b0, '0, "resetRestart");
            @(posedge clk);
            wrEn      <= 1'b0;
            frameMark <= 1'b0;
            cycles = 0;
            while (checksDone != expects.size() + 2 && cycles < 100) begin
                @(negedge clk);
                cycles++;
            end
            if (checksDone != expects.size() + 2) begin
                $display("checker did not finish all tests in time");
                ok = 1'b0;
            end
        end
        @(posedge clk);
        reportReq <= 1'b1;
        @(posedge clk);
        if (ok && errorCount == 0 && testCount == expects.size() + 2) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sifhChecker.sv ====
//**************************************
// sifh result checker
// compares DUT results with expected values and counts the tests
//**************************************
`timescale 1ns/1ps

module sifhChecker #(
    parameter int RES_BITS  = 16,
    parameter int NAME_BITS = 128
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 wrEn,
    input  logic                 frameMark,
    input  logic                 expHasResult,
    input  logic [RES_BITS-1:0]  expResult,
    input  logic [NAME_BITS-1:0] expName,
    input  logic [RES_BITS-1:0]  result,
    input  logic                 resultValid,
    input  logic                 windowValid,
    input  logic                 reportReq,
    output int                   errorCount,
    output int                   testCount,
    output int                   checksDone
);

    // edges from the last strobe to the sampled pulse
    localparam int LATENCY = 3;
    // shorter than one frame so the next frame end is never missed
    localparam int TIMEOUT = 10;

    // packed name to text, nulls dropped
    function automatic string nameText(input logic [NAME_BITS-1:0] packedName);
        string s;
        s = "";
        for (int i = NAME_BITS / 8 - 1; i >= 0; i--) begin
            if (packedName[i*8 +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, packedName[i*8 +: 8]);
            end
        end
        return s;
    endfunction

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("%s", msg);
    endtask

    //**************************************
    // result frame, value and latency
    //**************************************
    task automatic checkResult(input string name, input logic [RES_BITS-1:0] expected);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            seen = resultValid;
        end
        if (!seen) begin
            reportFailure($sformatf("%s: no resultValid within %0d cycles", name, TIMEOUT));
        end else if (cycles != LATENCY) begin
            errorCount++;
            $display("ERR %s latency expected %0d actual %0d", name, LATENCY, cycles);
        end else if (result !== expected) begin
            errorCount++;
            $display("ERR %s result expected %h actual %h", name, expected, result);
        end else begin
            $display("%s: ok, result %h", name, result);
        end
    endtask

    //**************************************
    // first frame after reset
    //**************************************
    // window comes up, no result pulse
    task automatic checkFirstFrame(input string name);
        int   cycles;
        logic up;
        cycles = 0;
        up     = 1'b0;
        if (windowValid) begin
            reportFailure($sformatf("%s: windowValid high before the frame ended", name));
        end
        while (!up && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            up = windowValid;
            if (resultValid) begin
                reportFailure($sformatf("%s: resultValid pulsed on a first frame", name));
            end
        end
        if (!up) begin
            reportFailure($sformatf("%s: windowValid did not rise after the frame", name));
        end else begin
            $display("%s: ok, windowValid after %0d cycles, no result", name, cycles);
        end
    endtask

    //**************************************
    // monitor loop
    //**************************************
    initial begin
        errorCount = 0;
        testCount  = 0;
        checksDone <= 0;
        forever begin
            @(posedge clk);
            // outputs cleared while reset is low
            if (!combin_res && (resultValid || windowValid)) begin
                reportFailure("resultValid or windowValid still high during reset");
            end else if (resultValid) begin
                reportFailure("resultValid pulsed where no result was expected");
            end
            // last strobe of a frame arms one test
            if (combin_res && wrEn && frameMark) begin
                testCount++;
                if (expHasResult) begin
                    checkResult(nameText(expName), expResult);
                end else begin
                    checkFirstFrame(nameText(expName));
                end
                checksDone <= checksDone + 1;
            end
        end
    end

    always @(posedge reportReq) begin
        $display("tests run %0d, errors %0d", testCount, errorCount);
    end

endmodule

// ==== sifhTop.sv ====
//**************************************
// sifh top level
// sequencer, coarse and fine histograms and peak combiner
//**************************************
`timescale 1ns/1ps

module sifhTop #(
    parameter int PIXELS            = sifhPkg::PIXELS,
    parameter int SAMPLES_PER_PIXEL = sifhPkg::SAMPLES_PER_PIXEL,
    parameter int ACQS_PER_FRAME    = sifhPkg::ACQS_PER_FRAME
) (
    input  logic                               clk,
    input  logic                               combin_res,
    input  logic                               wrEn,
    input  sifhPkg::timestampT                 data,
    output logic [PIXELS*sifhPkg::TS_BITS-1:0] result,
    output logic                               resultValid,
    output logic                               windowValid
);
    import sifhPkg::*;

    //**************************************
    // internal wiring
    //**************************************
    sampleS              sample;
    peakS [PIXELS-1:0]   coarsePeaks;
    peakS [PIXELS-1:0]   finePeaks;
    windowS [PIXELS-1:0] windows;
    logic                peaksReady;

    // tag samples with pixel and frame end
    acqSequencer #(
        .PIXELS            (PIXELS),
        .SAMPLES_PER_PIXEL (SAMPLES_PER_PIXEL),
        .ACQS_PER_FRAME    (ACQS_PER_FRAME)
    ) uSequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .data       (data),
        .sample     (sample)
    );

    // current frame coarse pass
    coarseHistogram #(
        .PIXELS (PIXELS)
    ) uCoarse (
        .clk        (clk),
        .combin_res (combin_res),
        .sample     (sample),
        .peaks      (coarsePeaks),
        .peaksReady (peaksReady)
    );

    // fine pass on windows from the previous frame
    fineHistogram #(
        .PIXELS (PIXELS)
    ) uFine (
        .clk        (clk),
        .combin_res (combin_res),
        .sample     (sample),
        .windows    (windows),
        .peaks      (finePeaks)
    );

    peakCombiner #(
        .PIXELS (PIXELS)
    ) uCombiner (
        .clk         (clk),
        .combin_res  (combin_res),
        .coarsePeaks (coarsePeaks),
        .finePeaks   (finePeaks),
        .peaksReady  (peaksReady),
        .windows     (windows),
        .result      (result),
        .resultValid (resultValid),
        .windowValid (windowValid)
    );

endmodule

// ==== peakCombiner.sv ====
//**************************************
// peak combiner
// turns frame peaks into next windows and per-pixel results
//**************************************
`timescale 1ns/1ps

module peakCombiner #(
    parameter int PIXELS = sifhPkg::PIXELS
) (
    input  logic                                clk,
    input  logic                                combin_res,
    input  sifhPkg::peakS [PIXELS-1:0]          coarsePeaks,
    input  sifhPkg::peakS [PIXELS-1:0]          finePeaks,
    input  logic                                peaksReady,
    output sifhPkg::windowS [PIXELS-1:0]        windows,
    output logic [PIXELS*sifhPkg::TS_BITS-1:0]  result,
    output logic                                resultValid,
    output logic                                windowValid
);
    import sifhPkg::*;

    // no result until a window exists
    typedef enum logic {
        NO_WINDOW,
        TRACKING
    } combStateT;

    combStateT           state;
    windowS [PIXELS-1:0] windowsQ;
    windowS [PIXELS-1:0] windowsNext;
    logic                produce;

    assign produce = peaksReady && (state == TRACKING);

    //**************************************
    // window rule
    //**************************************
    always_comb begin
        int lowCalc;
        lowCalc = 0;
        for (int p = 0; p < PIXELS; p++) begin
            // coarse bin start minus half a bin
            lowCalc = int'(coarsePeaks[p].bin) * BIN_WIDTH - BIN_WIDTH / 2;
            // keep the 2W window inside the timestamp range
            if (lowCalc < 0) begin
                lowCalc = 0;
            end else if (lowCalc > LOW_MAX) begin
                lowCalc = LOW_MAX;
            end
            windowsNext[p].low   = timestampT'(lowCalc);
            windowsNext[p].valid = 1'b1;
        end
    end

    // forward the new windows while peaksReady is high
    // so a sample right after the frame end sees them
    assign windows     = peaksReady ? windowsNext : windowsQ;
    assign windowValid = (state == TRACKING);

    //**************************************
    // state, windows, result pulse
    //**************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state       <= NO_WINDOW;
            windowsQ    <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= produce;
            if (peaksReady) begin
                windowsQ <= windowsNext;
                state    <= TRACKING;
            end
        end
    end

    //**************************************
    // result register
    //**************************************
    // fine bin plus the low of the window it was taken in
    always_ff @(posedge clk) begin
        if (produce) begin
            for (int p = 0; p < PIXELS; p++) begin
                result[p*TS_BITS +: TS_BITS] <= windowsQ[p].low + timestampT'(finePeaks[p].bin);
            end
        end
    end

endmodule

// ==== fineHistogram.sv ====
//**************************************
// fine histogram unit
// counts offsets inside each pixel window and tracks the fine peak
//**************************************
`timescale 1ns/1ps

module fineHistogram #(
    parameter int PIXELS = sifhPkg::PIXELS
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  sifhPkg::sampleS              sample,
    input  sifhPkg::windowS [PIXELS-1:0] windows,
    output sifhPkg::peakS [PIXELS-1:0]   peaks
);
    import sifhPkg::*;

    localparam int    DEPTH     = PIXELS * FINE_BINS;
    localparam int    ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam countT COUNT_MAX = '1;

    //**************************************
    // storage
    //**************************************
    // 2W bins per pixel
    countT countMem [DEPTH];
    logic [DEPTH-1:0] binValid;
    peakS [PIXELS-1:0] runPeak;

    windowS                curWin;
    timestampT             offset;
    logic                  inWindow;
    logic                  hit;
    fineBinT               fineBin;
    logic [ADDR_BITS-1:0]  addr;
    countT                 newCount;
    peakS [PIXELS-1:0]     peakNext;
    logic                  frameDone;

    // frame end arrives in lockstep with the coarse unit
    assign frameDone = sample.valid && sample.frameEnd;

    //**************************************
    // window filter
    //**************************************
    always_comb begin
        curWin = windows[sample.pixel];
        // offset from the window start
        offset = sample.ts - curWin.low;
        // low up to low + 2W - 1
        inWindow = curWin.valid && (sample.ts >= curWin.low) && (int'(offset) < FINE_BINS);
        hit      = sample.valid && inWindow;
        fineBin  = offset[FINE_BITS-1:0];
        addr     = ADDR_BITS'(int'(sample.pixel) * FINE_BINS + int'(fineBin));
    end

    //**************************************
    // count and peak compare
    //**************************************
    always_comb begin
        if (!binValid[addr]) begin
            newCount = countT'(1);
        end else if (countMem[addr] == COUNT_MAX) begin
            newCount = COUNT_MAX;
        end else begin
            newCount = countMem[addr] + 1'b1;
        end

        // earlier bin wins on a tie
        peakNext = runPeak;
        if (hit && (newCount > runPeak[sample.pixel].count)) begin
            peakNext[sample.pixel].count = newCount;
            peakNext[sample.pixel].bin   = fineBin;
        end
    end

    //**************************************
    // valid bitmap and running peaks
    //**************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            runPeak  <= '0;
        end else if (frameDone) begin
            binValid <= '0;
            runPeak  <= '0;
        end else begin
            runPeak <= peakNext;
            if (hit) begin
                binValid[addr] <= 1'b1;
            end
        end
    end

    //**************************************
    // count memory and published peaks
    //**************************************
    always_ff @(posedge clk) begin
        if (hit) begin
            countMem[addr] <= newCount;
        end
        // empty pixel publishes bin 0
        if (frameDone) begin
            peaks <= peakNext;
        end
    end

endmodule

// ==== coarseHistogram.sv ====
//**************************************
// coarse histogram unit
// bins the upper timestamp bits per pixel and tracks the peak bin
//**************************************
`timescale 1ns/1ps

module coarseHistogram #(
    parameter int PIXELS = sifhPkg::PIXELS
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  sifhPkg::sampleS              sample,
    output sifhPkg::peakS [PIXELS-1:0]   peaks,
    output logic                         peaksReady
);
    import sifhPkg::*;

    localparam int    DEPTH     = PIXELS * COARSE_BINS;
    localparam int    ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam countT COUNT_MAX = '1;

    //**************************************
    // storage
    //**************************************
    // count per pixel and bin
    countT countMem [DEPTH];
    // a clear bit marks a bin as empty in this frame
    logic [DEPTH-1:0] binValid;
    // running peak per pixel
    peakS [PIXELS-1:0] runPeak;

    coarseBinT             coarseBin;
    logic [ADDR_BITS-1:0]  addr;
    countT                 newCount;
    peakS [PIXELS-1:0]     peakNext;
    logic                  frameDone;

    assign frameDone = sample.valid && sample.frameEnd;

    //**************************************
    // bin lookup and peak compare
    //**************************************
    always_comb begin
        // top bits select the bin
        coarseBin = sample.ts[TS_BITS-1 -: COARSE_BITS];
        addr      = ADDR_BITS'(int'(sample.pixel) * COARSE_BINS + int'(coarseBin));

        // an empty bin starts at one, a full one stays at max
        if (!binValid[addr]) begin
            newCount = countT'(1);
        end else if (countMem[addr] == COUNT_MAX) begin
            newCount = COUNT_MAX;
        end else begin
            newCount = countMem[addr] + 1'b1;
        end

        // strictly greater, so a tie keeps the earlier bin
        peakNext = runPeak;
        if (sample.valid && (newCount > runPeak[sample.pixel].count)) begin
            peakNext[sample.pixel].count = newCount;
            peakNext[sample.pixel].bin   = fineBinT'(coarseBin);
        end
    end

    //**************************************
    // valid bitmap, running peaks, frame pulse
    //**************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid   <= '0;
            runPeak    <= '0;
            peaksReady <= 1'b0;
        end else begin
            peaksReady <= frameDone;
            if (frameDone) begin
                // one cycle clear of the whole histogram
                binValid <= '0;
                runPeak  <= '0;
            end else begin
                runPeak <= peakNext;
                if (sample.valid) begin
                    binValid[addr] <= 1'b1;
                end
            end
        end
    end

    //**************************************
    // count memory and published peaks
    //**************************************
    always_ff @(posedge clk) begin
        if (sample.valid) begin
            countMem[addr] <= newCount;
        end
        // peaks include the last sample of the frame
        if (frameDone) begin
            peaks <= peakNext;
        end
    end

endmodule

// ==== acqSequencer.sv ====
//**************************************
// acquisition sequencer
// tags each strobed timestamp with its pixel and the frame end
//**************************************
`timescale 1ns/1ps

module acqSequencer #(
    parameter int PIXELS            = sifhPkg::PIXELS,
    parameter int SAMPLES_PER_PIXEL = sifhPkg::SAMPLES_PER_PIXEL,
    parameter int ACQS_PER_FRAME    = sifhPkg::ACQS_PER_FRAME
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wrEn,
    input  sifhPkg::timestampT data,
    output sifhPkg::sampleS    sample
);
    import sifhPkg::*;

    localparam int SAMPLE_BITS = (SAMPLES_PER_PIXEL > 1) ? $clog2(SAMPLES_PER_PIXEL) : 1;
    localparam int ACQ_BITS    = (ACQS_PER_FRAME > 1) ? $clog2(ACQS_PER_FRAME) : 1;

    localparam logic [SAMPLE_BITS-1:0] LAST_SAMPLE = SAMPLE_BITS'(SAMPLES_PER_PIXEL - 1);
    localparam pixelIdxT               LAST_PIXEL  = PIX_BITS'(PIXELS - 1);
    localparam logic [ACQ_BITS-1:0]    LAST_ACQ    = ACQ_BITS'(ACQS_PER_FRAME - 1);

    // nested counters, sample index is the innermost
    logic [SAMPLE_BITS-1:0] sampleIdx;
    pixelIdxT               pixelIdx;
    logic [ACQ_BITS-1:0]    acqIdx;

    logic lastSample;
    logic lastPixel;
    logic lastAcq;

    // wrap conditions of each counter level
    assign lastSample = (sampleIdx == LAST_SAMPLE);
    assign lastPixel  = lastSample && (pixelIdx == LAST_PIXEL);
    assign lastAcq    = lastPixel && (acqIdx == LAST_ACQ);

    //**************************************
    // counters, only wrEn advances them
    //**************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleIdx <= '0;
            pixelIdx  <= '0;
            acqIdx    <= '0;
        end else if (wrEn) begin
            sampleIdx <= lastSample ? '0 : sampleIdx + 1'b1;
            if (lastSample) begin
                pixelIdx <= lastPixel ? '0 : pixelIdx + 1'b1;
            end
            if (lastPixel) begin
                acqIdx <= lastAcq ? '0 : acqIdx + 1'b1;
            end
        end
    end

    //**************************************
    // sample register
    //**************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sample <= '0;
        end else begin
            // valid only in the cycle after a strobe
            sample.valid <= wrEn;
            if (wrEn) begin
                sample.ts       <= data;
                sample.pixel    <= pixelIdx;
                sample.frameEnd <= lastAcq;
            end else begin
                sample.frameEnd <= 1'b0;
            end
        end
    end

endmodule

// ==== sifhPkg.sv ====
//**************************************
// sifh histogram package
// sizes, vector types and packed structs shared by the datapath
//**************************************
package sifhPkg;

    //**************************************
    // default sizes
    //**************************************
    // timestamp width
    parameter int TS_BITS           = 8;
    // upper bits that select a coarse bin
    parameter int COARSE_BITS       = 4;
    parameter int PIXELS            = 2;
    parameter int SAMPLES_PER_PIXEL = 2;
    parameter int ACQS_PER_FRAME    = 3;
    // counts saturate at all ones
    parameter int COUNT_BITS        = 4;

    //**************************************
    // derived sizes
    //**************************************
    // fine index covers two coarse bins
    parameter int FINE_BITS   = TS_BITS - COARSE_BITS + 1;
    parameter int COARSE_BINS = 1 << COARSE_BITS;
    // coarse bin width W
    parameter int BIN_WIDTH   = 1 << (TS_BITS - COARSE_BITS);
    // fine window spans 2W
    parameter int FINE_BINS   = 2 * BIN_WIDTH;
    // highest window low that keeps the window inside the range
    parameter int LOW_MAX     = (1 << TS_BITS) - FINE_BINS;
    parameter int PIX_BITS    = (PIXELS > 1) ? $clog2(PIXELS) : 1;

    //**************************************
    // vector types
    //**************************************
    typedef logic [TS_BITS-1:0]     timestampT;
    typedef logic [COARSE_BITS-1:0] coarseBinT;
    typedef logic [FINE_BITS-1:0]   fineBinT;
    typedef logic [COUNT_BITS-1:0]  countT;
    typedef logic [PIX_BITS-1:0]    pixelIdxT;

    // one registered sample with its tags
    typedef struct packed {
        timestampT ts;
        pixelIdxT  pixel;
        logic      valid;
        // last sample of the frame
        logic      frameEnd;
    } sampleS;

    // fine window of one pixel
    typedef struct packed {
        timestampT low;
        logic      valid;
    } windowS;

    // peak of one pixel histogram
    typedef struct packed {
        countT   count;
        fineBinT bin;
    } peakS;

endpackage
